/* verification/dramLoaderInput.txt */
# L <load-file line>, sent one character at a time and ended with a newline
# W <function> <address> <EBUS data> expected writes in hex, N <good> <bad> <done> counts
L ; DRAM load test, comment line
L C A,B,C,D
L D C,P,Blj,A]n,|M,JyH
L D C,D@,A,B,C,E
L Z B,@,C,D
L D F,@,C`A,Dh,F,xg,BHC,H@O,AZR
L D @,@,@
W 30 010 000ac0000
W 31 010 0005c0000
W 32 010 000340000
W 33 010 000880000
W 34 010 000b80000
W 30 012 000e00000
W 31 012 000040000
W 32 012 000180000
W 33 012 000040000
W 34 012 000a00000
W 30 014 000380000
W 31 014 000880000
W 32 014 0003c0000
W 33 014 0009c0000
W 34 014 0000c0000
N 02 01 1

/* verilog.f */
logic/dramLoaderPkg.sv
logic/asciiFieldDecoder.sv
logic/dramRecordParser.sv
logic/dramPairUnpacker.sv
logic/diagStrober.sv
logic/loaderStatus.sv
logic/dramLoaderTop.sv
verification/dramLoaderTb.sv

/* Makefile */
# DRAM loader simulation with Verilator

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, output in $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module dramLoaderTb -Mdir obj_dir -o simv
	./obj_dir/simv | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* verification/dramLoaderTb.sv */
// DRAM loader testbench
`timescale 1ns/10ps

module dramLoaderTb import dramLoaderPkg::*; ();

  localparam int StrobeCycles = 3;

  logic       clk;
  logic       rst;
  logic [7:0] charIn;
  logic       charReq;
  logic       charAck;
  tDiagWrite  diagBus;
  logic       diagStrobe;
  logic [7:0] goodLines;
  logic [7:0] badLines;
  logic       loadDone;

  // Stimulus and expected results from the data file
  logic [7:0]  charQ [$];
  tDiagWrite   expQ [$];
  logic [7:0]  expGood;
  logic [7:0]  expBad;
  logic        expDone;
  logic        loadOk;
  logic [31:0] lfsr;
  int          gap;
  int          errorCount = 0;
  int          checkCount = 0;
  int          limitCycles = 0;
  // Bus monitor state
  int          captured;
  int          highCycles;
  logic        strobeSeen;
  tDiagWrite   latchedBus;

  dramLoaderTop #(.StrobeCycles(StrobeCycles)) dut_i (
    .clk, .rst, .charIn, .charReq, .charAck,
    .diagBus, .diagStrobe, .goodLines, .badLines, .loadDone
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Helpers

  // Galois form with the taps of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    if (s[0]) return (s >> 1) ^ 32'h8020_0003;
    return s >> 1;
  endfunction

  task automatic checkValue(input logic [63:0] got, input logic [63:0] expected,
                            input string what);
    checkCount++;
    if (got !== expected) begin
      $display("Mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, got, expected);
      errorCount++;
    end
  endtask

  // Load text on L lines, expected writes on W lines and the counts on the N line
  task automatic readStimulus(output logic ok);
    int          fd;
    int          c;
    int          n;
    logic        gotCounts;
    logic [6:0]  fnVal;
    logic [8:0]  addrVal;
    logic [35:0] dataVal;
    tDiagWrite   w;
    ok = 1'b0;
    gotCounts = 1'b0;
    fd = $fopen("verification/dramLoaderInput.txt", "r");
    if (fd != 0) begin
      ok = 1'b1;
      c = $fgetc(fd);
      while (c != -1) begin
        if (c[7:0] == "L") begin
          c = $fgetc(fd);
          while (c != -1 && c != 10) begin
            charQ.push_back(c[7:0]);
            c = $fgetc(fd);
          end
          // Every load line ends in a newline
          charQ.push_back(8'h0a);
        end else if (c[7:0] == "W") begin
          n = $fscanf(fd, "%h %h %h", fnVal, addrVal, dataVal);
          if (n != 3) ok = 1'b0;
          w.func = tDiagFunction'(fnVal);
          w.addr = addrVal;
          w.data = dataVal;
          expQ.push_back(w);
        end else if (c[7:0] == "N") begin
          n = $fscanf(fd, "%h %h %h", expGood, expBad, expDone);
          if (n != 3) ok = 1'b0;
          gotCounts = 1'b1;
        end
        // Skip the rest of the line and any comment on it
        while (c != -1 && c != 10) c = $fgetc(fd);
        if (c != -1) c = $fgetc(fd);
      end
      $fclose(fd);
      ok = ok && gotCounts;
    end
  endtask

  // Four-phase handshake for one character
  task automatic sendChar(input logic [7:0] c);
    @(posedge clk);
    charIn  <= c;
    charReq <= 1'b1;
    @(posedge clk);
    while (!charAck) @(posedge clk);
    charReq <= 1'b0;
    @(posedge clk);
    while (charAck) @(posedge clk);
  endtask

  ////////////////////////////////////////////////////////////
  // Diagnostic bus monitor

  always @(posedge clk) begin
    if (rst) begin
      captured   <= 0;
      highCycles <= 0;
      strobeSeen <= 1'b0;
    end else begin
      if (diagStrobe && !strobeSeen) begin
        // Rising strobe is compared with the next expected write
        if (captured >= expQ.size()) begin
          $display("Unexpected diagnostic write at %0t ns, more writes than expected", $time);
          errorCount++;
        end else begin
          checkValue(diagBus.func, expQ[captured].func, "write function");
          checkValue(diagBus.addr, expQ[captured].addr, "write address");
          checkValue(diagBus.data, expQ[captured].data, "write data");
        end
        latchedBus <= diagBus;
        highCycles <= 1;
        captured   <= captured + 1;
      end else if (diagStrobe) begin
        checkValue(diagBus, latchedBus, "bus held during strobe");
        highCycles <= highCycles + 1;
      end else if (strobeSeen) begin
        // First cycle after the fall is the hold cycle
        checkValue(highCycles, StrobeCycles, "strobe length");
        checkValue(diagBus, latchedBus, "bus held after strobe");
      end
      strobeSeen <= diagStrobe;
    end
  end

  ////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    rst     = 1'b1;
    charReq = 1'b0;
    charIn  = 8'h00;
    lfsr    = 32'hd007_a6b1;
    readStimulus(loadOk);
    if (!loadOk) begin
      $display("The stimulus file is missing or malformed");
      $display("SIMULATION FAILED");
      $finish;
    end else begin
      limitCycles = charQ.size() * 10 + expQ.size() * 8 + 100;
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      foreach (charQ[i]) begin
        // Idle gap of 0 to 3 cycles from two LFSR bits
        gap = 0;
        repeat (2) begin
          gap  = (gap << 1) | int'(lfsr[0]);
          lfsr = lfsrStep(lfsr);
        end
        repeat (gap) @(posedge clk);
        sendChar(charQ[i]);
      end
      while (captured < expQ.size() || diagStrobe) @(posedge clk);
      // Quiet time to catch a stray write
      repeat (2 * (StrobeCycles + 2)) @(posedge clk);
      checkValue(captured, expQ.size(), "number of writes");
      checkValue(goodLines, expGood, "good line count");
      checkValue(badLines, expBad, "bad line count");
      checkValue(loadDone, expDone, "done flag");
      $display("Writes %0d of %0d, checks %0d, errors %0d",
               captured, expQ.size(), checkCount, errorCount);
      if (errorCount == 0) begin
        $display("SIMULATION PASSED");
      end else begin
        $display("SIMULATION FAILED");
      end
      $finish;
    end
  end

  // Watchdog with its budget set once the file is read
  initial begin
    wait (limitCycles > 0);
    repeat (limitCycles) @(posedge clk);
    $display("Timeout after %0d cycles, the load never finished", limitCycles);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* logic/dramLoaderTop.sv */
// DRAM microcode loader top
`timescale 1ns/10ps

module dramLoaderTop import dramLoaderPkg::*; #(
  parameter int StrobeCycles = 3
) (
  input  logic       clk,
  input  logic       rst,
  input  logic [7:0] charIn,
  input  logic       charReq,
  output logic       charAck,
  output tDiagWrite  diagBus,
  output logic       diagStrobe,
  output logic [7:0] goodLines,
  output logic [7:0] badLines,
  output logic       loadDone
);

  ////////////////////////////////////////////////////////////
  // Pipeline links

  tFieldWord field;
  logic      fieldReq;
  logic      fieldAck;
  tDramPair  pair;
  logic      pairReq;
  logic      pairAck;
  tDiagWrite write;
  logic      writeReq;
  logic      writeAck;
  // Parser results for the status block
  logic      lineGood;
  logic      lineBad;
  logic      endOfFile;

  asciiFieldDecoder fieldDecoder (
    .clk, .rst, .charIn, .charReq, .charAck,
    .field, .fieldReq, .fieldAck
  );

  dramRecordParser recordParser (
    .clk, .rst, .field, .fieldReq, .fieldAck,
    .pair, .pairReq, .pairAck,
    .lineGood, .lineBad, .endOfFile
  );

  dramPairUnpacker pairUnpacker (
    .clk, .rst, .pair, .pairReq, .pairAck,
    .write, .writeReq, .writeAck
  );

  diagStrober #(.StrobeCycles(StrobeCycles)) strober (
    .clk, .rst, .write, .writeReq, .writeAck,
    .diagBus, .diagStrobe
  );

  loaderStatus status (
    .clk, .rst, .lineGood, .lineBad, .endOfFile,
    .goodLines, .badLines, .loadDone
  );

endmodule

/* logic/loaderStatus.sv */
// Load status counters
`timescale 1ns/10ps

module loaderStatus (
  input  logic       clk,
  input  logic       rst,
  input  logic       lineGood,
  input  logic       lineBad,
  input  logic       endOfFile,
  output logic [7:0] goodLines,
  output logic [7:0] badLines,
  output logic       loadDone
);

  always_ff @(posedge clk) begin
    if (rst) begin
      goodLines <= '0;
      badLines  <= '0;
      loadDone  <= 1'b0;
    end else begin
      // Counters stick at full scale
      if (lineGood && goodLines != 8'hff) goodLines <= goodLines + 8'd1;
      if (lineBad && badLines != 8'hff) badLines <= badLines + 8'd1;
      // End record seen, sticky until reset
      if (endOfFile) loadDone <= 1'b1;
    end
  end

endmodule

/* logic/diagStrober.sv */
// Diagnostic bus strobe generator
`timescale 1ns/10ps

module diagStrober import dramLoaderPkg::*; #(
  parameter int StrobeCycles = 3
) (
  input  logic      clk,
  input  logic      rst,
  input  tDiagWrite write,
  input  logic      writeReq,
  output logic      writeAck,
  output tDiagWrite diagBus,
  output logic      diagStrobe
);

  localparam int CntW = (StrobeCycles > 1) ? $clog2(StrobeCycles) : 1;

  typedef enum logic [1:0] {ssIdle, ssStrobe, ssHold} tStrobeState;

  tStrobeState     state;
  logic [CntW-1:0] cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ssIdle;
      cnt        <= '0;
      writeAck   <= 1'b0;
      diagBus    <= '0;
      diagStrobe <= 1'b0;
    end else begin
      if (writeAck && !writeReq) writeAck <= 1'b0;

      unique case (state)
        ssIdle: if (writeReq && !writeAck) begin
          // Bus and strobe come up together
          diagBus    <= write;
          diagStrobe <= 1'b1;
          writeAck   <= 1'b1;
          cnt        <= CntW'(StrobeCycles - 1);
          state      <= ssStrobe;
        end
        ssStrobe: begin
          if (cnt == '0) begin
            diagStrobe <= 1'b0;
            state      <= ssHold;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        default: begin
          // Hold cycle done, bus released for the idle cycle
          diagBus <= '0;
          state   <= ssIdle;
        end
      endcase
    end
  end

endmodule

/* logic/dramPairUnpacker.sv */
// DRAM pair to diagnostic writes
`timescale 1ns/10ps

module dramPairUnpacker import dramLoaderPkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  tDramPair  pair,
  input  logic      pairReq,
  output logic      pairAck,
  output tDiagWrite write,
  output logic      writeReq,
  input  logic      writeAck
);

  typedef enum logic [2:0] {usIdle, usLoad, usSend, usWait, usAck} tUnpackState;

  tUnpackState state;
  logic [2:0]  fnIdx;
  tDiagWrite   nextWrite;
  tDramEvenOdd even;
  tDramEvenOdd odd;
  tDramCommon  common;

  assign even   = pair.even.eo;
  assign odd    = pair.odd.eo;
  assign common = pair.common.cm;

  ////////////////////////////////////////////////////////////
  // EBUS bit mapping of functions 60 to 64

  always_comb begin
    nextWrite.addr = pair.addr;
    nextWrite.data = '0;
    unique case (fnIdx)
      3'd0: begin
        nextWrite.func        = diagfLDRAM1;
        nextWrite.data[12:14] = even.a;
        nextWrite.data[15:17] = even.b;
      end
      3'd1: begin
        nextWrite.func        = diagfLDRAM2;
        nextWrite.data[12:14] = odd.a;
        nextWrite.data[15:17] = odd.b;
      end
      3'd2: begin
        nextWrite.func        = diagfLDRAM3;
        nextWrite.data[14:17] = common.j;
      end
      3'd3: begin
        nextWrite.func        = diagfLDRJEV;
        nextWrite.data[12]    = even.parity;
        nextWrite.data[15:17] = even.j[2:0];
      end
      default: begin
        // J7 is common but written from the odd word
        nextWrite.func        = diagfLDRJOD;
        nextWrite.data[12]    = odd.parity;
        nextWrite.data[14]    = odd.j[3];
        nextWrite.data[15:17] = odd.j[2:0];
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= usIdle;
      fnIdx    <= '0;
      pairAck  <= 1'b0;
      writeReq <= 1'b0;
    end else begin
      unique case (state)
        usIdle: if (pairReq && !pairAck) begin
          fnIdx <= '0;
          state <= usLoad;
        end
        usLoad: begin
          write    <= nextWrite;
          writeReq <= 1'b1;
          state    <= usSend;
        end
        usSend: if (writeAck) begin
          writeReq <= 1'b0;
          state    <= usWait;
        end
        usWait: if (!writeAck) begin
          // Pair is acknowledged only after the fifth write
          if (fnIdx == 3'd4) begin
            pairAck <= 1'b1;
            state   <= usAck;
          end else begin
            fnIdx <= fnIdx + 1'b1;
            state <= usLoad;
          end
        end
        default: if (!pairReq) begin
          pairAck <= 1'b0;
          state   <= usIdle;
        end
      endcase
    end
  end

endmodule

/* logic/dramRecordParser.sv */
// D record framing and pair playout
`timescale 1ns/10ps

module dramRecordParser import dramLoaderPkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  tFieldWord field,
  input  logic      fieldReq,
  output logic      fieldAck,
  output tDramPair  pair,
  output logic      pairReq,
  input  logic      pairAck,
  output logic      lineGood,
  output logic      lineBad,
  output logic      endOfFile
);

  localparam int BufDepth = 3 * MaxPairsPerLine;
  localparam int BufIdxW  = $clog2(BufDepth);
  localparam int PairCntW = $clog2(MaxPairsPerLine + 1);

  typedef enum logic [1:0] {psScan, psLoad, psSend, psWait} tParseState;

  tParseState          state;
  W16                  lineBuf [BufDepth];
  W16                  sum;
  W16                  sumNext;
  W16                  wordCount;
  W16                  addrWord;
  logic [1:0]          wordIdx;
  logic [1:0]          tripleCnt;
  logic [BufIdxW-1:0]  wrIdx;
  logic [BufIdxW-1:0]  rdIdx;
  logic [PairCntW-1:0] pairCnt;
  logic [PairCntW-1:0] pairsLeft;
  tDramAddress         lastAddr;
  tDramAddress         curAddr;
  tDramAddress         startAddr;
  logic                takeWord;
  logic                inDLine;
  logic                bufWrite;

  assign takeWord  = (state == psScan) && fieldReq && !fieldAck;
  assign inDLine   = (field.letter == "D");
  assign sumNext   = sum + field.word;
  // Address zero continues where the previous line ended
  assign startAddr = (addrWord == '0) ? lastAddr : addrWord[8:0];
  assign bufWrite  = takeWord && inDLine && (field.kind == fkData) && (wordIdx == 2'd2) &&
                     (pairCnt < PairCntW'(MaxPairsPerLine));

  // Line buffer holds the triples of one line
  always_ff @(posedge clk) begin
    if (bufWrite) lineBuf[wrIdx] <= field.word;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= psScan;
      fieldAck  <= 1'b0;
      pairReq   <= 1'b0;
      lineGood  <= 1'b0;
      lineBad   <= 1'b0;
      endOfFile <= 1'b0;
      sum       <= '0;
      wordIdx   <= '0;
      tripleCnt <= '0;
      wrIdx     <= '0;
      pairCnt   <= '0;
      lastAddr  <= '0;
    end else begin
      lineGood  <= 1'b0;
      lineBad   <= 1'b0;
      endOfFile <= 1'b0;
      if (fieldAck && !fieldReq) fieldAck <= 1'b0;

      unique case (state)
        psScan: begin
          if (takeWord) begin
            fieldAck <= 1'b1;
            if (field.kind == fkLetter) begin
              // New line, clear framing
              sum       <= '0;
              wordIdx   <= '0;
              tripleCnt <= '0;
              wrIdx     <= '0;
              pairCnt   <= '0;
            end else if (inDLine && field.kind == fkData) begin
              sum <= sumNext;
              if (wordIdx == 2'd0) begin
                wordCount <= field.word;
                wordIdx   <= 2'd1;
              end else if (wordIdx == 2'd1) begin
                addrWord <= field.word;
                wordIdx  <= 2'd2;
              end else if (bufWrite) begin
                wrIdx <= wrIdx + 1'b1;
                if (tripleCnt == 2'd2) begin
                  tripleCnt <= '0;
                  pairCnt   <= pairCnt + 1'b1;
                end else begin
                  tripleCnt <= tripleCnt + 1'b1;
                end
              end
            end else if (inDLine && field.kind == fkEol) begin
              // Negated checksum brings the sum to zero
              if (sumNext != '0) begin
                lineBad <= 1'b1;
              end else if (wordCount == '0 && addrWord == '0) begin
                endOfFile <= 1'b1;
                lastAddr  <= '0;
              end else begin
                lineGood  <= 1'b1;
                curAddr   <= startAddr;
                lastAddr  <= startAddr + tDramAddress'({pairCnt, 1'b0});
                rdIdx     <= '0;
                pairsLeft <= pairCnt;
                if (pairCnt != '0) state <= psLoad;
              end
            end
          end
        end
        psLoad: begin
          pair    <= '{addr: curAddr, even: lineBuf[rdIdx], odd: lineBuf[rdIdx + 1],
                       common: lineBuf[rdIdx + 2]};
          pairReq <= 1'b1;
          state   <= psSend;
        end
        psSend: begin
          if (pairAck) begin
            pairReq <= 1'b0;
            state   <= psWait;
          end
        end
        default: begin
          // Wait for the unpacker to finish its handshake
          if (!pairAck) begin
            if (pairsLeft == PairCntW'(1)) begin
              state <= psScan;
            end else begin
              pairsLeft <= pairsLeft - 1'b1;
              rdIdx     <= rdIdx + BufIdxW'(3);
              curAddr   <= curAddr + tDramAddress'(2);
              state     <= psLoad;
            end
          end
        end
      endcase
    end
  end

endmodule

/* logic/asciiFieldDecoder.sv */
// ASCIIized character decoder
`timescale 1ns/10ps

module asciiFieldDecoder import dramLoaderPkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic [7:0] charIn,
  input  logic       charReq,
  output logic       charAck,
  output tFieldWord  field,
  output logic       fieldReq,
  input  logic       fieldAck
);

  W16         accum;
  logic       atLineStart;
  logic [7:0] lineLetter;
  logic       linkIdle;
  logic       isSkip;
  logic       isComma;
  logic       isNewline;

  // Only take a character once the parser link is back to rest
  assign linkIdle  = !fieldReq && !fieldAck;
  assign isSkip    = (charIn == 8'h20) || (charIn == 8'h0d);
  assign isComma   = (charIn == 8'h2c);
  assign isNewline = (charIn == 8'h0a);

  always_ff @(posedge clk) begin
    if (rst) begin
      charAck     <= 1'b0;
      fieldReq    <= 1'b0;
      accum       <= '0;
      atLineStart <= 1'b1;
      lineLetter  <= '0;
    end else begin
      // Parser took the word
      if (fieldReq && fieldAck) fieldReq <= 1'b0;

      if (charAck && !charReq) begin
        charAck <= 1'b0;
      end else if (charReq && !charAck && linkIdle) begin
        charAck <= 1'b1;
        if (isNewline) begin
          // Last word of the line is the checksum
          field       <= '{word: accum, kind: fkEol, letter: lineLetter};
          fieldReq    <= 1'b1;
          accum       <= '0;
          atLineStart <= 1'b1;
          lineLetter  <= '0;
        end else if (isSkip) begin
          accum <= accum;
        end else if (atLineStart) begin
          // Record letter
          field       <= '{word: '0, kind: fkLetter, letter: charIn};
          fieldReq    <= 1'b1;
          lineLetter  <= charIn;
          atLineStart <= 1'b0;
        end else if (isComma) begin
          field    <= '{word: accum, kind: fkData, letter: lineLetter};
          fieldReq <= 1'b1;
          accum    <= '0;
        end else begin
          // Octal 100 masked off leaves the low six bits
          accum <= {accum[9:0], charIn[5:0]};
        end
      end
    end
  end

endmodule

/* logic/dramLoaderPkg.sv */
// DRAM loader shared types

package dramLoaderPkg;

  ////////////////////////////////////////////////////////////
  // Word widths

  // EBUS data width, bit 0 is the MSB as on the DEC machines
  localparam int EbusBits = 36;

  // Largest number of location pairs in one D line
  localparam int MaxPairsPerLine = 10;

  typedef logic [15:0] W16;
  typedef logic [0:EbusBits-1] W36;

  typedef logic [8:0] tDramAddress;

  // Diagnostic load functions for the DRAM (octal)
  typedef enum logic [6:0] {
    diagfLDRAM1 = 7'o60,
    diagfLDRAM2 = 7'o61,
    diagfLDRAM3 = 7'o62,
    diagfLDRJEV = 7'o63,
    diagfLDRJOD = 7'o64
  } tDiagFunction;

  ////////////////////////////////////////////////////////////
  // Triple word views

  // Even or odd word of a pair
  typedef struct packed {
    logic [1:0] spare15;
    logic [2:0] a;
    logic [2:0] b;
    logic [1:0] spare7;
    logic       parity;
    logic       spare4;
    // J7 in bit 3, J8 to J10 below it
    logic [3:0] j;
  } tDramEvenOdd;

  // Common word, J1 to J4 only
  typedef struct packed {
    logic [11:0] spare;
    logic [3:0]  j;
  } tDramCommon;

  typedef union packed {
    tDramEvenOdd eo;
    tDramCommon  cm;
  } tDramHalfWord;

  ////////////////////////////////////////////////////////////
  // Link payloads

  typedef enum logic [1:0] {
    fkData,
    fkLetter,
    fkEol
  } tFieldKind;

  // Decoder to parser
  typedef struct packed {
    W16         word;
    tFieldKind  kind;
    logic [7:0] letter;
  } tFieldWord;

  // Parser to unpacker
  typedef struct packed {
    tDramAddress  addr;
    tDramHalfWord even;
    tDramHalfWord odd;
    tDramHalfWord common;
  } tDramPair;

  // Unpacker to strober and onto the bus
  typedef struct packed {
    tDiagFunction func;
    tDramAddress  addr;
    W36           data;
  } tDiagWrite;

endpackage
